//--- dv/corr_tb.sv
//////////////////////////////
// correlator testbench
// LFSR stimulus, reference model and output compare
//////////////////////////////

`timescale 1ns/1ps

`include "corr_config.svh"

module corr_tb;

  import corr_pkg::*;

  localparam int NP = `CORR_NUM_PARALLEL;
  localparam int SW = `CORR_SAMPLE_WIDTH;
  localparam int AW = `CORR_ACC_WIDTH;
  localparam int L  = `CORR_LENGTH;
  localparam int NC = `CORR_NUM_CORRS;
  localparam int IN_W  = `CORR_IN_WIDTH;
  localparam int OUT_W = `CORR_OUT_WIDTH;
  localparam logic [NC*L-1:0] TAPS = `CORR_TAPS;

  // frames per test
  localparam int IMP_FRAMES  = 10;
  localparam int RAND_FRAMES = 40;
  localparam int BP_FRAMES   = 60;
  localparam int EXT_FRAMES  = 24;
  localparam int TOTAL_FRAMES = IMP_FRAMES + RAND_FRAMES + BP_FRAMES + EXT_FRAMES;

  // watchdog budget in slots per frame times a generous stall factor
  localparam int CLK_PERIOD = 4;
  localparam int BP_FACTOR  = 8;
  localparam int TIMEOUT_NS = (TOTAL_FRAMES * NUM_SLOTS * BP_FACTOR + 200) * CLK_PERIOD;

  logic             clk;
  logic             arst_n;
  logic             in_valid;
  logic [IN_W-1:0]  in_data;
  logic             in_ready;
  logic             out_valid;
  logic [OUT_W-1:0] out_data;
  corr_t            out_dest;
  logic             out_ready;

  // stimulus state
  logic [15:0] lfsr_q = 16'd44123;
  logic        bp_mode;
  string       test_name;

  // reference model state with k = 0 as the newest sample
  int               hist [NP][L];
  logic [OUT_W-1:0] exp_data_q [$];
  corr_t            exp_dest_q [$];
  int               impulse_idx;

  corr_top dut_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_dest  (out_dest),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // 16-bit fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic rand_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [IN_W-1:0] random_frame();
    logic [IN_W-1:0] f;
    for (int i = 0; i < IN_W; i++) begin
      f[i] = rand_bit();
    end
    return f;
  endfunction

  // same value on every lane
  function automatic logic [IN_W-1:0] fill_frame(input int value);
    logic [IN_W-1:0] f;
    for (int lane = 0; lane < NP; lane++) begin
      f[lane*SW +: SW] = sample_t'(value);
    end
    return f;
  endfunction

  // full-scale lanes picked at random between the two ends
  function automatic logic [IN_W-1:0] extreme_mix_frame();
    logic [IN_W-1:0] f;
    for (int lane = 0; lane < NP; lane++) begin
      f[lane*SW +: SW] = rand_bit() ? sample_t'(-32) : sample_t'(31);
    end
    return f;
  endfunction

  // one expected word per correlator for each accepted frame
  function automatic void corr_expect(input logic [IN_W-1:0] frame);
    int               acc;
    logic [OUT_W-1:0] word;
    for (int lane = 0; lane < NP; lane++) begin
      for (int k = L - 1; k > 0; k--) begin
        hist[lane][k] = hist[lane][k-1];
      end
      hist[lane][0] = int'($signed(frame[lane*SW +: SW]));
    end
    for (int c = 0; c < NC; c++) begin
      word = '0;
      for (int lane = 0; lane < NP; lane++) begin
        acc = 0;
        // a set tap bit adds and a clear one subtracts
        for (int k = 0; k < L; k++) begin
          if (TAPS[c*L + k]) begin
            acc = acc + hist[lane][k];
          end else begin
            acc = acc - hist[lane][k];
          end
        end
        word[lane*AW +: AW] = acc[AW-1:0];
      end
      exp_data_q.push_back(word);
      exp_dest_q.push_back(corr_t'(c));
    end
  endfunction

  // impulse response word idx comes from frame idx/NC of correlator idx%NC
  function automatic logic [OUT_W-1:0] impulse_word(input int idx);
    logic [OUT_W-1:0] w;
    int               k;
    int               c;
    k = idx / NC;
    c = idx % NC;
    for (int lane = 0; lane < NP; lane++) begin
      w[lane*AW +: AW] = TAPS[c*L + k] ? acc_t'(1) : acc_t'(-1);
    end
    return w;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1, "%s", reason);
  endtask

  // one cycle with inputs changed half a ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #0.5;
    if (bp_mode) begin
      out_ready = rand_bit();
    end else begin
      out_ready = 1'b1;
    end
  endtask

  // hold the frame until the handshake after a random idle gap under back-pressure
  task automatic drive_frame(input logic [IN_W-1:0] data);
    logic taken;
    while (bp_mode && rand_bit() == 1'b0) begin
      next_cycle();
    end
    in_valid = 1'b1;
    in_data  = data;
    do begin
      @(negedge clk);
      taken = in_ready;
      next_cycle();
    end while (!taken);
    in_valid = 1'b0;
  endtask

  task automatic start_phase(input string name, input logic bp);
    test_name = name;
    bp_mode   = bp;
  endtask

  // drain and then wait a few quiet cycles for stray words
  task automatic finish_phase();
    while (exp_data_q.size() != 0) begin
      next_cycle();
    end
    repeat (2 * NUM_SLOTS) next_cycle();
  endtask

  task automatic compare_output();
    logic [OUT_W-1:0] exp_data;
    corr_t            exp_dest;
    if (exp_data_q.size() == 0) begin
      abort_run("output word arrived with no accepted frame left to match it");
    end else begin
      exp_data = exp_data_q.pop_front();
      exp_dest = exp_dest_q.pop_front();
      check_value({test_name, " data"}, 64'(exp_data), 64'(out_data));
      check_value({test_name, " dest"}, 64'(exp_dest), 64'(out_dest));
      // impulse also checked straight against the tap words
      if (test_name == "impulse" && impulse_idx < L * NC) begin
        check_value("impulse tap", 64'(impulse_word(impulse_idx)), 64'(out_data));
        impulse_idx++;
      end
    end
  endtask

  //////////////////////////////
  // output compare ahead of input record
  //////////////////////////////

  always @(negedge clk) begin
    if (arst_n) begin
      if (out_valid && out_ready) begin
        compare_output();
      end
      if (in_valid && in_ready) begin
        corr_expect(in_data);
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    abort_run("watchdog expired before all results arrived");
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    in_valid    = 1'b0;
    in_data     = '0;
    out_ready   = 1'b1;
    arst_n      = 1'b0;
    bp_mode     = 1'b0;
    test_name   = "reset";
    impulse_idx = 0;
    repeat (3) @(posedge clk);
    #0.5;
    arst_n = 1'b1;

    // idle state after reset
    @(negedge clk);
    check_value("reset in_ready", 64'(1), 64'(in_ready));
    check_value("reset out_valid", 64'(0), 64'(out_valid));
    next_cycle();

    // one unit frame then zeros with history starting at zero
    start_phase("impulse", 1'b0);
    drive_frame(fill_frame(1));
    repeat (IMP_FRAMES - 1) drive_frame(fill_frame(0));
    finish_phase();

    start_phase("random", 1'b0);
    repeat (RAND_FRAMES) drive_frame(random_frame());
    finish_phase();

    // random gaps and random out_ready
    start_phase("backpressure", 1'b1);
    repeat (BP_FRAMES) drive_frame(random_frame());
    finish_phase();

    // full-scale samples whose sums stay inside the accumulator
    start_phase("extreme", 1'b0);
    repeat (EXT_FRAMES / 3) drive_frame(fill_frame(-32));
    repeat (EXT_FRAMES / 3) drive_frame(fill_frame(31));
    repeat (EXT_FRAMES / 3) drive_frame(extreme_mix_frame());
    finish_phase();

    repeat (20) next_cycle();
    if (exp_data_q.size() != 0) begin
      abort_run("expected results were still queued at the end of the run");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

//--- files.f
+incdir+include
source/corr_pkg.sv
source/corr_sequencer.sv
source/corr_adder_chain.sv
source/corr_collector.sv
source/corr_top.sv
dv/corr_tb.sv

//--- include/corr_config.svh
//////////////////////////////
// correlator configuration
// lane count, widths, correlator length and tap words
//////////////////////////////

`ifndef CORR_CONFIG_SVH
`define CORR_CONFIG_SVH

// lanes per input frame, power of two
`define CORR_NUM_PARALLEL 4

// signed sample width per lane
`define CORR_SAMPLE_WIDTH 6

// signed accumulator width, holds 8 x full-scale sample
`define CORR_ACC_WIDTH 12

// taps per correlator
`define CORR_LENGTH 8

// number of correlators, power of two
`define CORR_NUM_CORRS 2

// tap words, correlator 0 in the low byte
// bit k set means +1 for x[n-k], clear means -1
`define CORR_TAPS 16'h69B2

// packed stream widths, lane 0 in the low bits
`define CORR_IN_WIDTH (`CORR_NUM_PARALLEL * `CORR_SAMPLE_WIDTH)
`define CORR_OUT_WIDTH (`CORR_NUM_PARALLEL * `CORR_ACC_WIDTH)

`endif

//--- run.sh
#!/bin/sh
# compile with Verilator and run the correlator testbench
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f files.f --top-module corr_tb -o corr_sim &&
./obj_dir/corr_sim &&
echo "simulation finished" ||
{ echo "simulation failed"; exit 1; }

//--- source/corr_adder_chain.sv
//////////////////////////////
// correlator adder chain
// one sign-apply adder per tap, partial sums kept
// per slot between stages until the next frame
//////////////////////////////

`timescale 1ns/1ps

`include "corr_config.svh"

module corr_adder_chain (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     stall,
  // slot stream from the sequencer
  input  logic                     slot_valid,
  input  corr_pkg::slot_t          slot,
  input  corr_pkg::sample_t        sample,
  input  logic [`CORR_LENGTH-1:0]  taps,
  // finished sums to the collector
  output logic                     sum_valid,
  output corr_pkg::slot_t          sum_slot,
  output corr_pkg::acc_t           sum
);

  import corr_pkg::*;

  // sample widened once, shared by all stages
  acc_t sample_ext;
  // signed sample per stage
  acc_t term      [`CORR_LENGTH];
  // partial from the stage before, previous frame
  acc_t part_rd   [`CORR_LENGTH];
  // adder output per stage
  acc_t stage_sum [`CORR_LENGTH];
  logic advance;

  assign advance    = slot_valid & ~stall;
  assign sample_ext = acc_t'(sample);

  // first stage starts from zero
  assign part_rd[0] = '0;

  //////////////////////////////
  // stages
  //////////////////////////////

  genvar j;
  generate
    for (j = 0; j < `CORR_LENGTH; j++) begin : g_stage
      // tap bits reversed, stage 0 sees the oldest sample
      assign term[j] = taps[`CORR_LENGTH-1-j] ? sample_ext : -sample_ext;
      assign stage_sum[j] = part_rd[j] + term[j];

      if (j < `CORR_LENGTH - 1) begin : g_store
        // per-slot partial, read back by stage j+1 next frame
        acc_t part_q [NUM_SLOTS];

        always_ff @(posedge clk or negedge arst_n) begin
          if (!arst_n) begin
            // history before reset counts as zero
            for (int i = 0; i < NUM_SLOTS; i++) begin
              part_q[i] <= '0;
            end
          end else if (advance) begin
            part_q[slot] <= stage_sum[j];
          end
        end

        assign part_rd[j+1] = part_q[slot];
      end
    end
  endgenerate

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sum_valid <= 1'b0;
    end else if (!stall) begin
      sum_valid <= slot_valid;
    end
  end

  // last stage is the full correlation
  always_ff @(posedge clk) begin
    if (advance) begin
      sum_slot <= slot;
      sum      <= stage_sum[`CORR_LENGTH-1];
    end
  end

endmodule

//--- source/corr_collector.sv
//////////////////////////////
// correlator collector
// packs lane sums into one word per correlator and
// drives the output stream through a two-register buffer
//////////////////////////////

`timescale 1ns/1ps

`include "corr_config.svh"

module corr_collector (
  input  logic                        clk,
  input  logic                        arst_n,
  // sums from the adder chain
  input  logic                        sum_valid,
  input  corr_pkg::slot_t             sum_slot,
  input  corr_pkg::acc_t              sum,
  // pipeline hold
  output logic                        stall,
  // output stream
  output logic                        out_valid,
  output logic [`CORR_OUT_WIDTH-1:0]  out_data,
  output corr_pkg::corr_t             out_dest,
  input  logic                        out_ready
);

  import corr_pkg::*;

  localparam lane_t LAST_LANE = lane_t'(`CORR_NUM_PARALLEL - 1);

  // pending word, filled lane by lane
  logic                       pend_valid;
  logic [`CORR_OUT_WIDTH-1:0] pend_data;
  corr_t                      pend_dest;

  lane_t sum_lane;
  corr_t sum_corr;
  logic  sum_take;
  logic  word_done;
  logic  out_load;

  // slot back to lane and correlator
  assign sum_lane = lane_t'(sum_slot % `CORR_NUM_PARALLEL);
  assign sum_corr = corr_t'(sum_slot / `CORR_NUM_PARALLEL);

  // output register empty or handing off this cycle
  assign out_load = ~out_valid | out_ready;

  // both registers full and the sink not taking
  assign stall = pend_valid & out_valid & ~out_ready;

  assign sum_take  = sum_valid & ~stall;
  assign word_done = sum_take & (sum_lane == LAST_LANE);

  //////////////////////////////
  // pending register
  //////////////////////////////

  // a full pending word always drains unless stalled,
  // so new lanes can land here right away
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pend_valid <= 1'b0;
    end else if (word_done) begin
      pend_valid <= 1'b1;
    end else if (out_load) begin
      pend_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (sum_take) begin
      pend_data[sum_lane*`CORR_ACC_WIDTH +: `CORR_ACC_WIDTH] <= sum;
    end
    // dest taken with the last lane
    if (word_done) begin
      pend_dest <= sum_corr;
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (out_load) begin
      out_valid <= pend_valid;
    end
  end

  // word stays stable while waiting on out_ready
  always_ff @(posedge clk) begin
    if (out_load && pend_valid) begin
      out_data <= pend_data;
      out_dest <= pend_dest;
    end
  end

endmodule

//--- source/corr_pkg.sv
//////////////////////////////
// correlator types
// sample, sum and index types shared by the pipeline
//////////////////////////////

`include "corr_config.svh"

package corr_pkg;

  // index widths
  localparam int LANE_BITS = $clog2(`CORR_NUM_PARALLEL);
  // at least one bit, even with a single correlator
  localparam int CORR_BITS = (`CORR_NUM_CORRS > 1) ? $clog2(`CORR_NUM_CORRS) : 1;
  localparam int NUM_SLOTS = `CORR_NUM_PARALLEL * `CORR_NUM_CORRS;
  localparam int SLOT_BITS = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

  // one lane sample
  typedef logic signed [`CORR_SAMPLE_WIDTH-1:0] sample_t;

  // partial or final correlation sum
  typedef logic signed [`CORR_ACC_WIDTH-1:0] acc_t;

  // lane within a frame
  typedef logic [LANE_BITS-1:0] lane_t;

  // correlator number, also the output dest
  typedef logic [CORR_BITS-1:0] corr_t;

  // correlator major, lane minor
  // slot = corr * lanes + lane
  typedef logic [SLOT_BITS-1:0] slot_t;

endpackage

//--- source/corr_sequencer.sv
//////////////////////////////
// correlator sequencer
// accepts one frame, then issues its slots one per cycle
// with the lane sample and the correlator tap word
//////////////////////////////

`timescale 1ns/1ps

`include "corr_config.svh"

module corr_sequencer (
  input  logic                        clk,
  input  logic                        arst_n,
  // input stream
  input  logic                        in_valid,
  input  logic [`CORR_IN_WIDTH-1:0]   in_data,
  output logic                        in_ready,
  // pipeline hold from the collector
  input  logic                        stall,
  // slot stream to the adder chain
  output logic                        slot_valid,
  output corr_pkg::slot_t             slot,
  output corr_pkg::sample_t           sample,
  output logic [`CORR_LENGTH-1:0]     taps
);

  import corr_pkg::*;

  localparam slot_t LAST_SLOT = slot_t'(NUM_SLOTS - 1);
  localparam logic [`CORR_NUM_CORRS*`CORR_LENGTH-1:0] TAP_WORDS = `CORR_TAPS;

  // frame held for slots 1..last
  logic [`CORR_IN_WIDTH-1:0] frame_q;
  // next slot to issue while busy
  slot_t                     cnt_q;
  logic                      busy_q;

  logic                      accept;
  logic                      issue;
  slot_t                     issue_slot;
  lane_t                     issue_lane;
  corr_t                     issue_corr;
  logic [`CORR_IN_WIDTH-1:0] frame_sel;

  // ready only once the last slot of the previous frame is out
  assign in_ready = ~busy_q & ~stall;
  assign accept   = in_valid & in_ready;

  // slot 0 goes out straight from the input on acceptance
  assign issue      = accept | (busy_q & ~stall);
  assign issue_slot = accept ? '0 : cnt_q;
  assign frame_sel  = accept ? in_data : frame_q;

  // split slot into correlator and lane
  assign issue_lane = lane_t'(issue_slot % `CORR_NUM_PARALLEL);
  assign issue_corr = corr_t'(issue_slot / `CORR_NUM_PARALLEL);

  //////////////////////////////
  // frame latch and slot counter
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      frame_q <= in_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (issue) begin
      // frame done after the last slot
      if (issue_slot == LAST_SLOT) begin
        busy_q <= 1'b0;
        cnt_q  <= '0;
      end else begin
        busy_q <= 1'b1;
        cnt_q  <= slot_t'(issue_slot + 1'b1);
      end
    end
  end

  //////////////////////////////
  // slot output register
  //////////////////////////////

  // valid holds under stall
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slot_valid <= 1'b0;
    end else if (!stall) begin
      slot_valid <= issue;
    end
  end

  // sample and tap word per slot
  always_ff @(posedge clk) begin
    if (issue) begin
      slot   <= issue_slot;
      sample <= frame_sel[issue_lane*`CORR_SAMPLE_WIDTH +: `CORR_SAMPLE_WIDTH];
      taps   <= TAP_WORDS[issue_corr*`CORR_LENGTH +: `CORR_LENGTH];
    end
  end

endmodule

//--- source/corr_top.sv
//////////////////////////////
// streaming bit correlator
// sequencer, shared adder chain and output collector
//////////////////////////////

`timescale 1ns/1ps

`include "corr_config.svh"

module corr_top (
  input  logic                        clk,
  input  logic                        arst_n,
  // input stream, lane 0 in the low bits
  input  logic                        in_valid,
  input  logic [`CORR_IN_WIDTH-1:0]   in_data,
  output logic                        in_ready,
  // output stream, dest is the correlator
  output logic                        out_valid,
  output logic [`CORR_OUT_WIDTH-1:0]  out_data,
  output corr_pkg::corr_t             out_dest,
  input  logic                        out_ready
);

  import corr_pkg::*;

  // sequencer to chain
  logic                    slot_valid;
  slot_t                   slot;
  sample_t                 sample;
  logic [`CORR_LENGTH-1:0] taps;

  // chain to collector
  logic  sum_valid;
  slot_t sum_slot;
  acc_t  sum;

  // collector back to the pipeline
  logic  stall;

  corr_sequencer sequencer_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_ready   (in_ready),
    .stall      (stall),
    .slot_valid (slot_valid),
    .slot       (slot),
    .sample     (sample),
    .taps       (taps)
  );

  corr_adder_chain adder_chain_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .stall      (stall),
    .slot_valid (slot_valid),
    .slot       (slot),
    .sample     (sample),
    .taps       (taps),
    .sum_valid  (sum_valid),
    .sum_slot   (sum_slot),
    .sum        (sum)
  );

  corr_collector collector_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .sum_valid (sum_valid),
    .sum_slot  (sum_slot),
    .sum       (sum),
    .stall     (stall),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_dest  (out_dest),
    .out_ready (out_ready)
  );

endmodule
